//--- include/ahb_mtx_dec_macros.svh
// Decoder bus and address map macros

`ifndef AHB_MTX_DEC_MACROS_SVH
`define AHB_MTX_DEC_MACROS_SVH

// ------------------------------
// Bus widths
// ------------------------------

`define AHB_DATA_W      32          // HRDATA width
`define DEC_ADDR_MSB    31          // Top of decoded HADDR slice
`define DEC_ADDR_LSB    10          // 1 KB decode granule

// Mapped output stages, MI1 MI2 MI3 MI7 MI8 MI9
`define NUM_MI          6

// ------------------------------
// Address map, 22-bit slice units
// ------------------------------

// 0x2000_0000 - 0x2000_ffff
`define MI1_LO          22'h080000
`define MI1_HI          22'h08003f

// 0x4000_0000 - 0x4000_ffff
`define MI2_LO          22'h100000
`define MI2_HI          22'h10003f

// 0x4003_0000 - 0x5002_ffff
`define MI3_LO          22'h1000c0
`define MI3_HI          22'h1400bf

// Peripheral window, three adjacent regions
`define MI7_LO          22'h180100  // 0x6004_0000
`define MI7_HI          22'h180243  // 0x6009_0fff
`define MI8_LO          22'h180244  // 0x6009_1000
`define MI8_HI          22'h180247
`define MI9_LO          22'h180248  // 0x6009_2000
`define MI9_HI          22'h18024b

`endif

//--- verilog/ahb_mtx_dec_pkg.sv
// Decoder types and port mapping

`include "ahb_mtx_dec_macros.svh"

package ahb_mtx_dec_pkg;

    // Data-phase owner, codes follow the MI numbering
    typedef enum logic [4:0] {
        NONE = 5'd0,                    // Nothing in data phase
        MI1  = 5'd1,
        MI2  = 5'd2,
        MI3  = 5'd3,
        MI7  = 5'd7,
        MI8  = 5'd8,
        MI9  = 5'd9,
        DFLT = 5'd16                    // Local default slave
    } port_id_t;

    typedef enum logic [1:0] {
        IDLE, BUSY, NONSEQ, SEQ
    } htrans_t;

    typedef enum logic [1:0] {
        OKAY  = 2'b00,
        ERROR = 2'b01
    } hresp_t;

    typedef logic [2:0] mi_idx_t;       // Position in per-stage vectors

    // Address-phase request from the input stage
    typedef struct packed {
        logic                                  sel;
        logic [`DEC_ADDR_MSB:`DEC_ADDR_LSB]    decode_addr;
        htrans_t                               trans;
    } dec_req_t;

    // Data-phase return of one responder
    typedef struct packed {
        logic                    readyout;
        hresp_t                  resp;
        logic [`AHB_DATA_W-1:0]  rdata;
    } slv_rsp_t;

    // Port code to vector position, 7 when not an output stage
    function automatic mi_idx_t mi_index(port_id_t port);
        case (port)
            MI1:     return 3'd0;
            MI2:     return 3'd1;
            MI3:     return 3'd2;
            MI7:     return 3'd3;
            MI8:     return 3'd4;
            MI9:     return 3'd5;
            default: return 3'd7;
        endcase
    endfunction

    // Inverse of mi_index
    function automatic port_id_t mi_port(mi_idx_t idx);
        case (idx)
            3'd0:    return MI1;
            3'd1:    return MI2;
            3'd2:    return MI3;
            3'd3:    return MI7;
            3'd4:    return MI8;
            3'd5:    return MI9;
            default: return DFLT;
        endcase
    endfunction

endpackage

//--- verilog/ahb_mtx_addr_decode.sv
// Address phase port decode

`include "ahb_mtx_dec_macros.svh"

module ahb_mtx_addr_decode
(
    // Input stage request
    input  ahb_mtx_dec_pkg::dec_req_t   dec_req,
    input  ahb_mtx_dec_pkg::port_id_t   data_port,     // Current data-phase owner
    input  logic [`NUM_MI-1:0]          active_mi,     // Output stage active flags

    output ahb_mtx_dec_pkg::port_id_t   addr_port,     // Port chosen for this address
    output logic [`NUM_MI-1:0]          sel_mi,        // One-hot HSEL to output stages
    output logic                        sel_dflt,      // HSEL to default slave
    output logic                        active_dec     // Active level of chosen stage
);

    import ahb_mtx_dec_pkg::*;

    // ------------------------------
    // Region table
    // ------------------------------

    // Entries in MI1 MI2 MI3 MI7 MI8 MI9 order, lowest index wins
    localparam logic [`DEC_ADDR_MSB:`DEC_ADDR_LSB] REGION_LO [`NUM_MI] = '{
        `MI1_LO, `MI2_LO, `MI3_LO, `MI7_LO, `MI8_LO, `MI9_LO
    };
    localparam logic [`DEC_ADDR_MSB:`DEC_ADDR_LSB] REGION_HI [`NUM_MI] = '{
        `MI1_HI, `MI2_HI, `MI3_HI, `MI7_HI, `MI8_HI, `MI9_HI
    };

    mi_idx_t addr_idx;                  // Vector position of addr_port

    // ------------------------------
    // Map lookup
    // ------------------------------

    // An IDLE leaves the owning stage selected, so an IDLE
    // after a transfer does not bounce HSEL to a new port
    always_comb
    begin : p_addr_port_comb
        logic in_region;
        logic hold;
        logic hit;

        addr_port = DFLT;               // Unmapped by default
        hit       = 1'b0;
        for (mi_idx_t i = 3'd0; i < 3'(`NUM_MI); i++)
        begin
            in_region = (dec_req.decode_addr >= REGION_LO[i]) &&
                        (dec_req.decode_addr <= REGION_HI[i]);
            hold      = (dec_req.trans == IDLE) && (data_port == mi_port(i));
            // Owner of an IDLE beats any earlier region
            if (hold || (!hit && in_region))
            begin
                addr_port = mi_port(i);
                hit       = 1'b1;       // Later regions lose
            end
        end
    end

    assign addr_idx = mi_index(addr_port);

    // ------------------------------
    // Select fan-out
    // ------------------------------

    always_comb
    begin : p_sel_comb
        sel_mi   = '0;
        sel_dflt = 1'b0;
        if (dec_req.sel)
        begin
            if (addr_idx < 3'(`NUM_MI))
                sel_mi[addr_idx] = 1'b1;
            else
                sel_dflt = 1'b1;        // Nothing mapped, local slave takes it
        end
    end

    // Default slave is always ready to accept
    assign active_dec = (addr_idx < 3'(`NUM_MI)) ? active_mi[addr_idx] : 1'b1;

endmodule

//--- verilog/ahb_mtx_data_phase.sv
// Data phase owner and response return

`include "ahb_mtx_dec_macros.svh"

module ahb_mtx_data_phase
(
    input  logic                        HCLK,
    input  logic                        HRESETn,
    input  logic                        HREADYS,       // Input stage HREADY

    input  ahb_mtx_dec_pkg::port_id_t   addr_port,     // From address decode
    input  ahb_mtx_dec_pkg::slv_rsp_t   mi_rsp [`NUM_MI], // Output stage returns
    input  ahb_mtx_dec_pkg::slv_rsp_t   dflt_rsp,      // Default slave return

    output ahb_mtx_dec_pkg::port_id_t   data_port,     // Owner of the data phase
    output ahb_mtx_dec_pkg::slv_rsp_t   rsp_s          // Back to input stage
);

    import ahb_mtx_dec_pkg::*;

    // Response with no transfer in flight
    localparam slv_rsp_t IDLE_RSP = '{
        readyout: 1'b1,
        resp:     OKAY,
        rdata:    '0
    };

    mi_idx_t data_idx;                  // Vector position of data_port

    // ------------------------------
    // Owner register
    // ------------------------------

    // HREADYS rather than the routed ready decides the update,
    // the input stage may accept while its own HREADYOUT is low
    always_ff @(posedge HCLK)
    begin : p_data_port_seq
        if (!HRESETn)
            data_port <= NONE;
        else if (HREADYS)
            data_port <= addr_port;     // Address phase becomes data phase
    end

    assign data_idx = mi_index(data_port);

    // ------------------------------
    // Return mux
    // ------------------------------

    always_comb
    begin : p_rsp_comb
        rsp_s = IDLE_RSP;
        if (data_idx < 3'(`NUM_MI))
        begin
            rsp_s = mi_rsp[data_idx];   // Mapped output stage
        end
        else if (data_port == DFLT)
        begin
            rsp_s       = dflt_rsp;
            rsp_s.rdata = '0;           // No read data from unmapped space
        end
    end

endmodule

//--- verilog/ahb_mtx_default_slave.sv
// Default slave for unmapped space

module ahb_mtx_default_slave
(
    input  logic                        HCLK,
    input  logic                        HRESETn,
    input  logic                        HREADYS,
    input  logic                        sel_dflt,      // HSEL from decode
    input  ahb_mtx_dec_pkg::htrans_t    trans,         // Input port HTRANS

    output ahb_mtx_dec_pkg::slv_rsp_t   dflt_rsp
);

    import ahb_mtx_dec_pkg::*;

    logic trans_req;                    // Real transfer accepted here
    logic err_wait;                     // First ERROR cycle, ready low
    logic err_last;                     // Second ERROR cycle, ready high

    // Only NONSEQ and SEQ need an ERROR, IDLE and BUSY get OKAY
    assign trans_req = sel_dflt && ((trans == NONSEQ) || (trans == SEQ));

    // ------------------------------
    // Error sequencer
    // ------------------------------

    // The wait cycle is what pulls HREADYS low, so it always
    // moves on; the other states hold while HREADYS is low
    always_ff @(posedge HCLK)
    begin : p_err_seq
        if (!HRESETn)
        begin
            err_wait <= 1'b0;
            err_last <= 1'b0;
        end
        else if (err_wait)
        begin
            err_wait <= 1'b0;
            err_last <= 1'b1;           // On to ready high with ERROR
        end
        else if (HREADYS)
        begin
            err_wait <= trans_req;
            err_last <= 1'b0;
        end
    end

    assign dflt_rsp.readyout = ~err_wait;
    assign dflt_rsp.resp     = (err_wait || err_last) ? ERROR : OKAY;
    assign dflt_rsp.rdata    = '0;      // Never returns data

endmodule

//--- verilog/ahb_mtx_dec.sv
// Input port address decoder

`include "ahb_mtx_dec_macros.svh"

module ahb_mtx_dec
(
    // Common AHB signals
    input  logic                        HCLK,
    input  logic                        HRESETn,

    // Input stage
    input  logic                        HREADYS,       // Transfer done
    input  ahb_mtx_dec_pkg::dec_req_t   dec_req,

    // Output stages
    input  logic [`NUM_MI-1:0]          active_mi,
    input  ahb_mtx_dec_pkg::slv_rsp_t   mi_rsp [`NUM_MI],

    output logic [`NUM_MI-1:0]          sel_mi,        // One-hot HSEL
    output logic                        active_dec,
    output ahb_mtx_dec_pkg::slv_rsp_t   rsp_s          // HREADYOUTS HRESPS HRDATAS
);

    import ahb_mtx_dec_pkg::*;

    port_id_t addr_port;                // Address-phase choice
    port_id_t data_port;                // Registered data-phase owner
    logic     sel_dflt;
    slv_rsp_t dflt_rsp;

    // ------------------------------
    // Address phase
    // ------------------------------

    ahb_mtx_addr_decode u_addr_decode (
        .dec_req    (dec_req),
        .data_port  (data_port),        // For the IDLE hold
        .active_mi  (active_mi),
        .addr_port  (addr_port),
        .sel_mi     (sel_mi),
        .sel_dflt   (sel_dflt),
        .active_dec (active_dec)
    );

    // ------------------------------
    // Data phase
    // ------------------------------

    ahb_mtx_data_phase u_data_phase (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HREADYS    (HREADYS),
        .addr_port  (addr_port),
        .mi_rsp     (mi_rsp),
        .dflt_rsp   (dflt_rsp),
        .data_port  (data_port),
        .rsp_s      (rsp_s)
    );

    // Unmapped addresses end up here
    ahb_mtx_default_slave u_default_slave (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HREADYS    (HREADYS),
        .sel_dflt   (sel_dflt),
        .trans      (dec_req.trans),
        .dflt_rsp   (dflt_rsp)
    );

endmodule

//--- verif/ahb_mtx_dec_properties.sv
// Decoder bound assertions

`include "ahb_mtx_dec_macros.svh"

module ahb_mtx_dec_properties
(
    input  logic                        HCLK,
    input  logic                        HRESETn,
    input  ahb_mtx_dec_pkg::dec_req_t   dec_req,
    input  ahb_mtx_dec_pkg::port_id_t   data_port,     // Internal owner register
    input  logic [`NUM_MI-1:0]          sel_mi,
    input  ahb_mtx_dec_pkg::slv_rsp_t   rsp_s
);

    import ahb_mtx_dec_pkg::*;

    // ------------------------------
    // Select rules
    // ------------------------------

    // At most one output stage per address
    a_sel_onehot : assert property (
        @(posedge HCLK) disable iff (!HRESETn) $onehot0(sel_mi)
    ) else $error("sel_mi drives more than one output stage");

    a_sel_off : assert property (
        @(posedge HCLK) disable iff (!HRESETn) (!dec_req.sel) |-> (sel_mi == '0)
    ) else $error("sel_mi active while dec_req.sel is low");

    // ------------------------------
    // Response rules
    // ------------------------------

    a_dflt_rdata : assert property (
        @(posedge HCLK) disable iff (!HRESETn) (data_port == DFLT) |-> (rsp_s.rdata == '0)
    ) else $error("Read data returned from unmapped space");

endmodule

bind ahb_mtx_dec ahb_mtx_dec_properties u_properties (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .dec_req   (dec_req),
    .data_port (data_port),
    .sel_mi    (sel_mi),
    .rsp_s     (rsp_s)
);

//--- verif/tb_ahb_mtx_dec.sv
// Decoder directed testbench

`include "ahb_mtx_dec_macros.svh"

module tb_ahb_mtx_dec;

    import ahb_mtx_dec_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS  = 6;
    // Region bounds, MI1 MI2 MI3 MI7 MI8 MI9
    localparam logic [21:0] REGION_LO [`NUM_MI] = '{
        `MI1_LO, `MI2_LO, `MI3_LO, `MI7_LO, `MI8_LO, `MI9_LO
    };
    localparam logic [21:0] REGION_HI [`NUM_MI] = '{
        `MI1_HI, `MI2_HI, `MI3_HI, `MI7_HI, `MI8_HI, `MI9_HI
    };
    localparam slv_rsp_t IDLE_RSP = '{readyout: 1'b1, resp: OKAY, rdata: '0};
    localparam slv_rsp_t WAIT_RSP = '{readyout: 1'b0, resp: ERROR, rdata: '0};
    localparam slv_rsp_t LAST_RSP = '{readyout: 1'b1, resp: ERROR, rdata: '0};

    logic               HCLK;
    logic               HRESETn;
    logic               HREADYS;
    dec_req_t           dec_req;
    logic [`NUM_MI-1:0] active_mi;
    slv_rsp_t           mi_rsp [`NUM_MI];       // Output stage models
    logic [`NUM_MI-1:0] sel_mi;
    logic               active_dec;
    slv_rsp_t           rsp_s;

    slv_rsp_t           stage_rsp [`NUM_MI];    // Expected stage returns
    logic [31:0]        lfsr = 32'h4caccc2d;
    string              test_name;

    ahb_mtx_dec u_dut (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HREADYS    (HREADYS),
        .dec_req    (dec_req),
        .active_mi  (active_mi),
        .mi_rsp     (mi_rsp),
        .sel_mi     (sel_mi),
        .active_dec (active_dec),
        .rsp_s      (rsp_s)
    );

    initial
    begin : p_clk
        HCLK = 1'b0;
        forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    // Taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [21:0] rand_addr(input mi_idx_t idx);
        logic [31:0] r;
        r = rand_bits(22);
        return REGION_LO[idx] + r[21:0] % (REGION_HI[idx] - REGION_LO[idx] + 22'd1);
    endfunction

    // Below MI1, a hole in the map
    function automatic logic [21:0] unmapped_addr();
        logic [31:0] r;
        r = rand_bits(19);
        return {3'b000, r[18:0]};
    endfunction

    function automatic logic [`NUM_MI-1:0] onehot(input mi_idx_t idx);
        logic [`NUM_MI-1:0] v;
        v      = '0;
        v[idx] = 1'b1;
        return v;
    endfunction

    task automatic drive_req(input logic sel, input logic [21:0] addr, input htrans_t trans);
        dec_req_t req;
        req.sel         = sel;
        req.decode_addr = addr;
        req.trans       = trans;
        @(posedge HCLK);
        dec_req <= req;
    endtask

    // Low for two sampled edges, all inputs back to idle
    task automatic pulse_reset();
        @(posedge HCLK);
        HRESETn   <= 1'b0;
        HREADYS   <= 1'b0;
        dec_req   <= '0;
        active_mi <= '0;
        for (mi_idx_t i = 3'd0; i < 3'(`NUM_MI); i++)
            mi_rsp[i] <= '0;
        repeat (2) @(posedge HCLK);
        HRESETn <= 1'b1;
    endtask

    task automatic load_stages();
        for (mi_idx_t i = 3'd0; i < 3'(`NUM_MI); i++)
        begin
            stage_rsp[i].readyout = 1'b1;
            stage_rsp[i].resp     = OKAY;
            stage_rsp[i].rdata    = rand_bits(`AHB_DATA_W);
            mi_rsp[i]            <= stage_rsp[i];
        end
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic stop_on_error();
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_sel(input logic [`NUM_MI-1:0] exp, input logic [`NUM_MI-1:0] act);
        if (act !== exp)
        begin
            $display("** Error %s sel_mi: expected %b, actual %b", test_name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string sig, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("** Error %s %s: expected %b, actual %b", test_name, sig, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_resp(input hresp_t exp, input hresp_t act);
        if (act !== exp)
        begin
            $display("** Error %s HRESPS: expected %s, actual %s (%0d)",
                     test_name, exp.name(), act.name(), act);
            stop_on_error();
        end
    endtask

    task automatic check_data(input logic [`AHB_DATA_W-1:0] exp, act);
        if (act !== exp)
        begin
            $display("** Error %s HRDATAS: expected %h, actual %h", test_name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_return(input slv_rsp_t exp);
        check_bit("HREADYOUTS", exp.readyout, rsp_s.readyout);
        check_resp(exp.resp, rsp_s.resp);
        check_data(exp.rdata, rsp_s.rdata);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic reset_values();
        test_name = "reset_values";
        pulse_reset();
        @(posedge HCLK);
        load_stages();                  // Busy stages, but nobody owns the data phase
        @(negedge HCLK);
        check_return(IDLE_RSP);
        check_sel('0, sel_mi);
    endtask

    task automatic address_map();
        test_name = "address_map";
        pulse_reset();                  // HREADYS stays low, selects only
        for (mi_idx_t i = 3'd0; i < 3'(`NUM_MI); i++)
        begin
            drive_req(1'b1, rand_addr(i), NONSEQ);
            @(negedge HCLK);
            check_sel(onehot(i), sel_mi);
        end
        drive_req(1'b1, unmapped_addr(), NONSEQ);
        @(negedge HCLK);
        check_sel('0, sel_mi);
        drive_req(1'b0, rand_addr(3'd2), NONSEQ);
        @(negedge HCLK);
        check_sel('0, sel_mi);
    endtask

    task automatic active_return();
        logic [31:0]        r;
        logic [`NUM_MI-1:0] pattern;
        test_name = "active_return";
        pulse_reset();
        for (mi_idx_t i = 3'd0; i < 3'(`NUM_MI); i++)
        begin
            r       = rand_bits(`NUM_MI);
            pattern = r[`NUM_MI-1:0];
            drive_req(1'b1, rand_addr(i), NONSEQ);
            active_mi <= pattern;
            @(negedge HCLK);
            check_bit("active_dec", pattern[i], active_dec);
            drive_req(1'b1, rand_addr(i), NONSEQ);
            active_mi <= ~pattern;      // Other level of the same bit
            @(negedge HCLK);
            check_bit("active_dec", ~pattern[i], active_dec);
        end
        drive_req(1'b1, unmapped_addr(), NONSEQ);
        active_mi <= '0;
        @(negedge HCLK);
        check_bit("active_dec", 1'b1, active_dec);
    endtask

    task automatic data_routing();
        test_name = "data_routing";
        pulse_reset();
        drive_req(1'b1, rand_addr(3'd3), NONSEQ);   // MI7 address accepted next edge
        HREADYS <= 1'b1;
        load_stages();
        stage_rsp[0].resp = ERROR;
        mi_rsp[0]        <= stage_rsp[0];
        drive_req(1'b1, rand_addr(3'd0), NONSEQ);   // MI7 owns, MI1 waits
        HREADYS <= 1'b0;
        @(negedge HCLK);
        check_return(stage_rsp[3]);
        @(posedge HCLK);
        stage_rsp[3].readyout = 1'b0;   // Stage stretches its data phase
        stage_rsp[3].rdata    = rand_bits(`AHB_DATA_W);
        mi_rsp[3]            <= stage_rsp[3];
        @(negedge HCLK);
        check_return(stage_rsp[3]);
        @(posedge HCLK);
        HREADYS              <= 1'b1;
        stage_rsp[3].readyout = 1'b1;
        mi_rsp[3]            <= stage_rsp[3];
        @(negedge HCLK);
        check_return(stage_rsp[3]);     // Still MI7 until HREADYS is sampled
        @(posedge HCLK);
        @(negedge HCLK);
        check_return(stage_rsp[0]);
    endtask

    task automatic idle_hold();
        test_name = "idle_hold";
        pulse_reset();
        drive_req(1'b1, rand_addr(3'd2), NONSEQ);
        HREADYS <= 1'b1;
        drive_req(1'b1, rand_addr(3'd0), IDLE);     // MI3 owns, IDLE aims at MI1
        @(negedge HCLK);
        check_sel(onehot(3'd2), sel_mi);
        drive_req(1'b1, unmapped_addr(), IDLE);
        @(negedge HCLK);
        check_sel(onehot(3'd2), sel_mi);
        drive_req(1'b1, rand_addr(3'd0), NONSEQ);   // Real transfer moves on
        @(negedge HCLK);
        check_sel(onehot(3'd0), sel_mi);
    endtask

    task automatic default_error();
        test_name = "default_error";
        pulse_reset();
        drive_req(1'b1, unmapped_addr(), NONSEQ);
        HREADYS <= 1'b1;
        load_stages();                  // Stage data must not leak through
        drive_req(1'b0, unmapped_addr(), IDLE);
        HREADYS <= 1'b0;                // Input stage follows ready low
        @(negedge HCLK);
        check_return(WAIT_RSP);
        @(posedge HCLK);
        HREADYS <= 1'b1;
        @(negedge HCLK);
        check_return(LAST_RSP);
        drive_req(1'b1, unmapped_addr(), IDLE);
        @(negedge HCLK);
        check_return(IDLE_RSP);
        @(posedge HCLK);
        @(negedge HCLK);
        check_return(IDLE_RSP);         // IDLE to unmapped space is zero wait
    endtask

    initial
    begin : p_watchdog
        #(NUM_TESTS * 200);
        $display("Watchdog expired, the tests hung and did not finish in time");
        stop_on_error();
    end

    initial
    begin : p_main
        HRESETn   = 1'b0;
        HREADYS   = 1'b0;
        dec_req   = '0;
        active_mi = '0;
        for (mi_idx_t i = 3'd0; i < 3'(`NUM_MI); i++)
            mi_rsp[i] = '0;
        reset_values();
        address_map();
        active_return();
        data_routing();
        idle_hold();
        default_error();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- ahb_mtx_dec.f
+incdir+include
verilog/ahb_mtx_dec_pkg.sv
verilog/ahb_mtx_addr_decode.sv
verilog/ahb_mtx_data_phase.sv
verilog/ahb_mtx_default_slave.sv
verilog/ahb_mtx_dec.sv
verif/ahb_mtx_dec_properties.sv
verif/tb_ahb_mtx_dec.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_ahb_mtx_dec
FILELIST  := ahb_mtx_dec.f
BUILD_DIR := obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
